/* Bender.yml */
package:
  name: exposure_metering

sources:
  - metering_pkg.sv
  - pixel_band_decoder.sv
  - band_histogram_counter.sv
  - metering_result_latch.sv
  - metering_top.sv
  - target: simulation
    files:
      - metering_assertions.sv
      - tb_metering.sv

/* band_histogram_counter.sv */
// Execute stage of the metering pipeline.
// Keeps five saturating band counters per colour channel. The counters
// restart at frame start, so the counts always describe the current frame.

`timescale 1ns/1ps
`default_nettype none

module band_histogram_counter #(
    parameter int unsigned counter_width = 24
) (
    input  logic                                                clock_in,
    input  logic                                                rst,
    input  metering_pkg::decoded_pixel_t                        decoded,
    output logic [3*metering_pkg::band_count*counter_width-1:0] counts
);

    import metering_pkg::*;

    typedef struct packed {
        logic [band_count-1:0][counter_width-1:0] red_bands;
        logic [band_count-1:0][counter_width-1:0] green_bands;
        logic [band_count-1:0][counter_width-1:0] blue_bands;
    } count_t;

    count_t count_q;

    assign counts = count_q;

    // Per-band increment requests, already qualified by count enable.
    band_select_t red_hit;
    band_select_t green_hit;
    band_select_t blue_hit;

    assign red_hit   = decoded.red & {band_count{decoded.count_enable}};
    assign green_hit = decoded.green & {band_count{decoded.count_enable}};
    assign blue_hit  = decoded.blue & {band_count{decoded.count_enable}};

    // Next value of one counter.
    // At frame start the counter restarts from the pixel arriving with it.
    function automatic logic [counter_width-1:0] next_count(
        input logic [counter_width-1:0] count,
        input logic                     hit,
        input logic                     start
    );
        logic [counter_width-1:0] result;
        if (start) begin
            result = counter_width'(hit);
        end else if (hit && (count != '1)) begin
            result = count + 1'b1;
        end else begin
            // Holds when idle or when already at all ones.
            result = count;
        end
        return result;
    endfunction

    always_ff @(posedge clock_in) begin
        if (rst) begin
            count_q <= '0;
        end else begin
            for (int b = 0; b < band_count; b++) begin
                count_q.red_bands[b] <= next_count(
                    count_q.red_bands[b],
                    red_hit[b],
                    decoded.frame_start
                );
                count_q.green_bands[b] <= next_count(
                    count_q.green_bands[b],
                    green_hit[b],
                    decoded.frame_start
                );
                count_q.blue_bands[b] <= next_count(
                    count_q.blue_bands[b],
                    blue_hit[b],
                    decoded.frame_start
                );
            end
        end
    end

endmodule

`default_nettype wire

/* compile.f */
metering_pkg.sv
pixel_band_decoder.sv
band_histogram_counter.sv
metering_result_latch.sv
metering_top.sv
metering_assertions.sv
tb_metering.sv

/* metering_assertions.sv */
// Concurrent checks on the metering top level, bound into metering_top.
// Failing assertions also raise failure_count for the testbench to watch.

`timescale 1ns/1ps
`default_nettype none

module metering_assertions #(
    parameter int unsigned counter_width = 24
) (
    input logic                                                clock_in,
    input logic                                                rst,
    input logic                                                frame_valid,
    input logic                                                metering_ready,
    input logic [3*metering_pkg::band_count*counter_width-1:0] metering
);

    int failure_count = 0;

    // Results only appear in vertical blanking.
    ready_rise_outside_frame: assert property (
        @(posedge clock_in) disable iff (rst)
        $rose(metering_ready) |-> !frame_valid
    ) else begin
        failure_count++;
        $error("metering_ready rose while frame_valid was high");
    end

    ready_low_after_reset: assert property (
        @(posedge clock_in)
        $past(rst) |-> !metering_ready
    ) else begin
        failure_count++;
        $error("metering_ready was high after reset");
    end

    // Published counts hold while ready stays high.
    result_stable_while_ready: assert property (
        @(posedge clock_in) disable iff (rst)
        metering_ready && $past(metering_ready) |-> $stable(metering)
    ) else begin
        failure_count++;
        $error("results changed while metering_ready was high");
    end

endmodule

bind metering_top metering_assertions #(
    .counter_width (counter_width)
) u_assertions (
    .clock_in       (clock_in),
    .rst            (rst),
    .frame_valid    (frame_valid),
    .metering_ready (metering_ready),
    .metering       (metering)
);

`default_nettype wire

/* metering_golden.txt */
// Hex words. First word is the frame count, then one record per frame:
// lines ppl blank mode red green blue pixels, red b0-b4, green b0-b4, blue b0-b4.
// Mode 0 holds each channel at the given value. Mode 1 takes LFSR pixels,
// its counts are zero here and follow from the band rule.
8
// Values just below and at the first limits.
4 6 3 0 cb cc 198 18
18 0 0 0 0
0 18 0 0 0
0 18 0 0 0
// Values at and just below the middle limits.
3 5 2 0 199 264 265 f
0 0 f 0 0
0 0 f 0 0
0 0 0 f 0
// Top limit and full scale.
5 4 4 0 331 332 3ff 14
0 0 0 14 0
0 0 0 0 14
0 0 0 0 14
// Zero, full scale and one above the first limit.
2 7 1 0 0 3ff cd e
e 0 0 0 0
0 0 0 0 e
0 e 0 0 0
// LFSR pixels with line blanking.
6 a 5 1 0 0 0 3c
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
// LFSR pixels, longer lines.
8 10 3 1 0 0 0 80
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0
// 1152 pixels per band, counters saturate at 3ff.
24 20 1 0 64 1f4 384 480
3ff 0 0 0 0
0 0 3ff 0 0
0 0 0 0 3ff
// LFSR pixels after saturation, counters must restart.
4 8 2 1 0 0 0 20
0 0 0 0 0
0 0 0 0 0
0 0 0 0 0

/* metering_pkg.sv */
// Shared definitions for the exposure metering pipeline.
// Holds the pixel and band constants and the structs passed between stages.
// Count structs depend on the counter width and are declared in the modules.

`default_nettype none

package metering_pkg;

    // Width of one colour channel.
    localparam int unsigned pixel_width = 10;

    // Five equal brightness bands.
    localparam int unsigned band_count = 5;

    // Ascending upper band limits, band 0 at index 0.
    // A value below limit n and not below limit n-1 belongs to band n,
    // values from the last limit upward belong to the top band.
    localparam logic [band_count-2:0][pixel_width-1:0] band_limit = {
        10'd818,
        10'd613,
        10'd409,
        10'd204
    };

    // One debayered pixel from the camera.
    typedef struct packed {
        logic [pixel_width-1:0] red;
        logic [pixel_width-1:0] green;
        logic [pixel_width-1:0] blue;
    } rgb_pixel_t;

    // One-hot band choice, bit n set for band n.
    typedef logic [band_count-1:0] band_select_t;

    // Decode stage output.
    // The frame marks are single-cycle pulses.
    typedef struct packed {
        band_select_t red;
        band_select_t green;
        band_select_t blue;
        logic         count_enable;
        logic         frame_start;
        logic         frame_end;
    } decoded_pixel_t;

endpackage

`default_nettype wire

/* metering_result_latch.sv */
// Result stage of the metering pipeline.
// Captures the band counts when a frame ends and raises the ready level.
// Ready falls again when the next frame starts, while the results
// hold until the following frame end.

`timescale 1ns/1ps
`default_nettype none

module metering_result_latch #(
    parameter int unsigned counter_width = 24
) (
    input  logic                                                clock_in,
    input  logic                                                rst,
    input  metering_pkg::decoded_pixel_t                        decoded,
    input  logic [3*metering_pkg::band_count*counter_width-1:0] counts,
    output logic [3*metering_pkg::band_count*counter_width-1:0] metering,
    output logic                                                metering_ready
);

    always_ff @(posedge clock_in) begin
        if (rst) begin
            metering       <= '0;
            metering_ready <= 1'b0;
        end else if (decoded.frame_end) begin
            // The last pixel of the frame is already in the counts here.
            metering       <= counts;
            metering_ready <= 1'b1;
        end else if (decoded.frame_start) begin
            metering_ready <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* metering_top.sv */
// Top level of the exposure metering block.
// Takes one debayered pixel per clock with the camera valid levels and
// publishes fifteen band counts per frame with a ready level.
// Results are valid two cycles after frame valid falls.

`timescale 1ns/1ps
`default_nettype none

module metering_top #(
    parameter int unsigned counter_width = 24
) (
    input  logic                                                clock_in,
    input  logic                                                rst,
    input  metering_pkg::rgb_pixel_t                            pixel,
    input  logic                                                line_valid,
    input  logic                                                frame_valid,
    output logic [3*metering_pkg::band_count*counter_width-1:0] metering,
    output logic                                                metering_ready
);

    import metering_pkg::*;

    // Live counts of the frame in progress.
    typedef struct packed {
        logic [band_count-1:0][counter_width-1:0] red_bands;
        logic [band_count-1:0][counter_width-1:0] green_bands;
        logic [band_count-1:0][counter_width-1:0] blue_bands;
    } count_t;

    decoded_pixel_t decoded;
    count_t         counts;

    pixel_band_decoder u_decoder (
        .clock_in    (clock_in),
        .rst         (rst),
        .pixel       (pixel),
        .line_valid  (line_valid),
        .frame_valid (frame_valid),
        .decoded     (decoded)
    );

    band_histogram_counter #(
        .counter_width (counter_width)
    ) u_counter (
        .clock_in (clock_in),
        .rst      (rst),
        .decoded  (decoded),
        .counts   (counts)
    );

    metering_result_latch #(
        .counter_width (counter_width)
    ) u_result (
        .clock_in       (clock_in),
        .rst            (rst),
        .decoded        (decoded),
        .counts         (counts),
        .metering       (metering),
        .metering_ready (metering_ready)
    );

endmodule

`default_nettype wire

/* pixel_band_decoder.sv */
// Pixel decode stage of the metering pipeline.
// Sorts each channel value into a one-hot brightness band and marks frame
// edges. Everything appears one cycle after the pixel is sampled.

`timescale 1ns/1ps
`default_nettype none

module pixel_band_decoder (
    input  logic                         clock_in,
    input  logic                         rst,
    input  metering_pkg::rgb_pixel_t     pixel,
    input  logic                         line_valid,
    input  logic                         frame_valid,
    output metering_pkg::decoded_pixel_t decoded
);

    import metering_pkg::*;

    // Frame valid from the previous cycle, for edge detection.
    logic frame_valid_q;

    // Lowest band whose limit lies above the value, else the top band.
    function automatic band_select_t classify(input logic [pixel_width-1:0] value);
        band_select_t band;
        band = '0;
        band[band_count-1] = 1'b1;
        // Walk downward so the smallest matching limit wins.
        for (int i = band_count - 2; i >= 0; i--) begin
            if (value < band_limit[i]) begin
                band = '0;
                band[i] = 1'b1;
            end
        end
        return band;
    endfunction

    always_ff @(posedge clock_in) begin
        if (rst) begin
            frame_valid_q <= 1'b0;
            decoded       <= '0;
        end else begin
            frame_valid_q <= frame_valid;

            decoded.red   <= classify(pixel.red);
            decoded.green <= classify(pixel.green);
            decoded.blue  <= classify(pixel.blue);

            // Only pixels inside both valid windows are counted.
            decoded.count_enable <= line_valid && frame_valid;

            // First cycle of frame valid high.
            decoded.frame_start <= frame_valid && !frame_valid_q;

            // First cycle of frame valid low after a frame.
            decoded.frame_end <= !frame_valid && frame_valid_q;
        end
    end

endmodule

`default_nettype wire

/* tb_metering.sv */
// Testbench for the exposure metering block.
// Plays the frames described in the golden file through metering_top and
// checks the band counts, the ready level and how long results hold.

`timescale 1ns/1ps
`default_nettype none

module tb_metering;

    import metering_pkg::*;

    localparam int counter_width = 10;
    localparam int count_max     = (1 << counter_width) - 1;
    localparam int record_words  = 23;

    typedef struct packed {
        logic [band_count-1:0][counter_width-1:0] red_bands;
        logic [band_count-1:0][counter_width-1:0] green_bands;
        logic [band_count-1:0][counter_width-1:0] blue_bands;
    } result_t;

    logic       clock_in;
    logic       rst;
    rgb_pixel_t pixel;
    logic       line_valid;
    logic       frame_valid;
    result_t    metering;
    logic       metering_ready;

    logic [15:0] golden [0:255];
    logic [15:0] lfsr_state;
    longint      watchdog_ns;
    int          frame_total;
    bit          had_frame;

    // What the outputs must show, and the counts of the frame in flight.
    int shown_counts [3][5];
    int model_counts [3][5];

    metering_top #(
        .counter_width (counter_width)
    ) u_dut (
        .clock_in       (clock_in),
        .rst            (rst),
        .pixel          (pixel),
        .line_valid     (line_valid),
        .frame_valid    (frame_valid),
        .metering       (metering),
        .metering_ready (metering_ready)
    );

    always #10 clock_in = ~clock_in;

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic random_value(output logic [pixel_width-1:0] value);
        value = '0;
        for (int i = 0; i < pixel_width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[pixel_width-2:0], lfsr_state[0]};
        end
    endtask

    // Band limits 204, 409, 613 and 818.
    function automatic int band_of(input int value);
        if (value < 204) return 0;
        if (value < 409) return 1;
        if (value < 613) return 2;
        if (value < 818) return 3;
        return 4;
    endfunction

    function automatic string channel_name(input int ch);
        if (ch == 0) return "red";
        if (ch == 1) return "green";
        return "blue";
    endfunction

    function automatic int result_count(input int ch, input int b);
        if (ch == 0) return metering.red_bands[b];
        if (ch == 1) return metering.green_bands[b];
        return metering.blue_bands[b];
    endfunction

    function automatic int field(input int f, input int pos);
        return golden[1 + f * record_words + pos];
    endfunction

    task automatic check_value(
        input logic [31:0] actual,
        input logic [31:0] expected,
        input string       what
    );
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic check_results(input string what);
        for (int ch = 0; ch < 3; ch++) begin
            for (int b = 0; b < band_count; b++) begin
                check_value(result_count(ch, b), shown_counts[ch][b],
                            $sformatf("%s, %s band %0d", what, channel_name(ch), b));
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clock_in);
        #2;
    endtask

    task automatic count_model(input int ch, input int value);
        int b;
        b = band_of(value);
        if (model_counts[ch][b] < count_max) begin
            model_counts[ch][b]++;
        end
    endtask

    task automatic drive_pixel(input int mode, input rgb_pixel_t fixed_pixel, input bit counted);
        rgb_pixel_t value;
        value = fixed_pixel;
        if (mode == 1) begin
            random_value(value.red);
            random_value(value.green);
            random_value(value.blue);
        end
        pixel = value;
        if (counted) begin
            count_model(0, value.red);
            count_model(1, value.green);
            count_model(2, value.blue);
        end
    endtask

    // One cycle inside the frame. Ready falls two edges after frame valid rises.
    task automatic frame_step(input int cycle);
        next_cycle();
        check_value(metering_ready, (cycle < 2) ? had_frame : 1'b0, "ready during frame");
        check_results("held result");
    endtask

    task automatic play_frame(input int f);
        int         lines;
        int         ppl;
        int         blank;
        int         mode;
        int         cycle;
        int         sum;
        rgb_pixel_t fixed_pixel;
        lines = field(f, 0);
        ppl   = field(f, 1);
        blank = field(f, 2);
        mode  = field(f, 3);
        fixed_pixel.red   = pixel_width'(field(f, 4));
        fixed_pixel.green = pixel_width'(field(f, 5));
        fixed_pixel.blue  = pixel_width'(field(f, 6));
        model_counts = '{default: 0};
        cycle = 0;
        for (int l = 0; l < lines; l++) begin
            for (int p = 0; p < ppl; p++) begin
                frame_step(cycle);
                cycle++;
                frame_valid = 1'b1;
                line_valid  = 1'b1;
                drive_pixel(mode, fixed_pixel, 1'b1);
            end
            // Line blanking keeps the pixel data moving without counting it.
            if (l != lines - 1) begin
                for (int g = 0; g < blank; g++) begin
                    frame_step(cycle);
                    cycle++;
                    line_valid = 1'b0;
                    drive_pixel(mode, fixed_pixel, 1'b0);
                end
            end
        end
        next_cycle();
        check_value(metering_ready, 0, "ready at last pixel");
        frame_valid = 1'b0;
        line_valid  = 1'b0;
        next_cycle();
        check_value(metering_ready, 0, "ready one edge after frame end");
        next_cycle();
        for (int ch = 0; ch < 3; ch++) begin
            for (int b = 0; b < band_count; b++) begin
                shown_counts[ch][b] = (mode == 0) ? field(f, 8 + ch * 5 + b)
                                                  : model_counts[ch][b];
            end
        end
        had_frame = 1'b1;
        check_value(metering_ready, 1, "ready two edges after frame end");
        check_results($sformatf("frame %0d result", f));
        if (mode == 1) begin
            for (int ch = 0; ch < 3; ch++) begin
                sum = 0;
                for (int b = 0; b < band_count; b++) begin
                    sum += result_count(ch, b);
                end
                check_value(sum, field(f, 7), $sformatf("%s pixel sum", channel_name(ch)));
            end
        end
        for (int v = 0; v < blank; v++) begin
            next_cycle();
            check_value(metering_ready, 1, "ready in vertical blanking");
            check_results("result in vertical blanking");
        end
    endtask

    task automatic load_golden();
        $readmemh("metering_golden.txt", golden);
        if ($isunknown(golden[0]) || golden[0] == 0) begin
            $display("The golden file is missing or holds no frames");
            $display("Testbench failed");
            $fatal(1, "No stimulus");
        end
    endtask

    initial begin
        longint cycles;
        clock_in     = 1'b0;
        rst          = 1'b1;
        pixel        = '0;
        line_valid   = 1'b0;
        frame_valid  = 1'b0;
        lfsr_state   = 16'd84;
        had_frame    = 1'b0;
        watchdog_ns  = 0;
        shown_counts = '{default: 0};
        load_golden();
        frame_total = golden[0];
        // Frame length plus end of frame and blanking, with margin.
        cycles = 40;
        for (int f = 0; f < frame_total; f++) begin
            cycles += field(f, 0) * field(f, 1) + (field(f, 0) - 1) * field(f, 2)
                      + field(f, 2) + 4;
        end
        watchdog_ns = 2 * cycles * 20;
        repeat (10) @(posedge clock_in);
        #2;
        rst = 1'b0;
        repeat (3) begin
            next_cycle();
            check_value(metering_ready, 0, "ready after reset");
            check_results("result after reset");
        end
        for (int f = 0; f < frame_total; f++) begin
            play_frame(f);
        end
        if (u_dut.u_assertions.failure_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("%0d bound assertion failures", u_dut.u_assertions.failure_count);
            $display("Testbench failed");
            $fatal(1, "Assertion failures");
        end
    end

    // Watchdog.
    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("The run timed out after %0d ns before all frames were played", watchdog_ns);
        $display("Testbench failed");
        $fatal(1, "Timeout");
    end

    // A bound assertion failure ends the run at once.
    initial begin
        wait (u_dut.u_assertions.failure_count != 0);
        $display("A bound assertion on metering_top failed");
        $display("Testbench failed");
        $fatal(1, "Assertion failure");
    end

endmodule

`default_nettype wire
